//--- nf_bus_pkg.sv
// nf_bus_pkg
// shared types and constants of the data-memory bus
// bus word, master request, slave select and address map,
// plus the register offsets and enums used by the GPIO and timer slaves
package nf_bus_pkg;

    typedef logic [31 : 0] word_t;                  // address and data word

    typedef struct packed {
        word_t  addr;                               // byte address
        logic   we;                                 // write enable
        word_t  wd;                                 // write data
    } dm_req_t;

    localparam int slave_n = 3;                     // ram, gpio, timer

    typedef logic [slave_n-1 : 0] slave_sel_t;      // one-hot slave select

    // select bit positions
    localparam int sel_ram  = 0;
    localparam int sel_gpio = 1;
    localparam int sel_tmr  = 2;

    // address map, 64 KiB window per slave
    localparam word_t slave_mask = 32'hffff_0000;
    localparam word_t ram_base   = 32'h0000_0000;
    localparam word_t gpio_base  = 32'h0001_0000;
    localparam word_t tmr_base   = 32'h0002_0000;

    typedef enum logic [3 : 0] {
        TMR_CNT  = 4'h0,                            // count, read only
        TMR_CMP  = 4'h4,                            // compare value
        TMR_CTRL = 4'h8                             // mode in bits 1:0
    } tmr_reg_e;

    typedef enum logic [1 : 0] {
        TMR_OFF      = 2'd0,
        TMR_ONESHOT  = 2'd1,
        TMR_PERIODIC = 2'd2
    } tmr_mode_e;

    typedef enum logic [1 : 0] {
        TMR_IDLE = 2'd0,
        TMR_RUN  = 2'd1,
        TMR_DONE = 2'd2
    } tmr_state_e;

    typedef enum logic [3 : 0] {
        GPIO_OUT = 4'h0,                            // output register, rw
        GPIO_IN  = 4'h4                             // synchronized pins, ro
    } gpio_reg_e;

endpackage : nf_bus_pkg

//--- nf_router_dec.sv
// nf_router_dec
// address decoder for the data-memory router
// masks the master address and compares it with each slave base,
// unmapped addresses give an all-zero select
`timescale 1ns/1ps

module nf_router_dec (
    input   nf_bus_pkg::word_t      addr,       // master address
    output  nf_bus_pkg::slave_sel_t slave_sel   // one-hot select
);

    import nf_bus_pkg::*;

    word_t  page;                               // address bits under the mask

    assign page = addr & slave_mask;

    always_comb begin
        slave_sel           = '0;               // unmapped by default
        slave_sel[sel_ram]  = (page == ram_base);
        slave_sel[sel_gpio] = (page == gpio_base);
        slave_sel[sel_tmr]  = (page == tmr_base);
    end

endmodule : nf_router_dec

//--- nf_router.sv
// nf_router
// routes load/store requests of the processor to the slaves
// write enable gated per slave by the decoded select, select
// registered to line up with the one-cycle slave read registers,
// read data chosen by an AND-OR mux over the registered select
`timescale 1ns/1ps

module nf_router (
    input   logic                                           clk,
    input   logic                                           rst_n,
    // master side
    input   nf_bus_pkg::dm_req_t                            req,    // master request
    output  nf_bus_pkg::word_t                              rd_dm,  // master read data
    // slave side
    output  nf_bus_pkg::slave_sel_t                         we_s,   // per slave write enable
    input   nf_bus_pkg::word_t [nf_bus_pkg::slave_n-1 : 0]  rd_s    // slave read data
);

    import nf_bus_pkg::*;

    slave_sel_t slave_sel;                      // decoded this cycle
    slave_sel_t sel_q;                          // select of last cycle's request

    nf_router_dec nf_router_dec_0 (
        .addr       ( req.addr  ),              // master address
        .slave_sel  ( slave_sel )               // one-hot select
    );

    assign we_s = {slave_n{req.we}} & slave_sel;    // only the hit slave writes

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_q <= '0;                        // rd_dm reads as zero after reset
        end else begin
            sel_q <= slave_sel;                 // matches slave read latency
        end
    end

    // and-or mux, zero select passes zero
    always_comb begin
        rd_dm = '0;
        for (int i = 0; i < slave_n; i++) begin
            rd_dm = rd_dm | ({32{sel_q[i]}} & rd_s[i]);
        end
    end

endmodule : nf_router

//--- nf_ram.sv
// nf_ram
// single-port word RAM on the data-memory bus
// word index from address bits above bit 1, wrapping at RAM_DEPTH,
// registered read that returns the old word on a same-cycle write
`timescale 1ns/1ps

module nf_ram #(
    parameter int RAM_DEPTH = 64                // words, power of two
) (
    input   logic                   clk,
    input   nf_bus_pkg::dm_req_t    req,        // forwarded request
    input   logic                   we,         // gated write enable
    output  nf_bus_pkg::word_t      rd          // registered read data
);

    localparam int AW = $clog2(RAM_DEPTH);      // index width

    logic [31 : 0]  mem [RAM_DEPTH];            // word storage
    logic [AW-1 : 0] idx;                       // word index

    assign idx = req.addr[2 +: AW];             // byte address to word, modulo depth

    always_ff @(posedge clk) begin
        rd <= mem[idx];                         // read-first, sees old word
        if (we) begin
            mem[idx] <= req.wd;
        end
    end

endmodule : nf_ram

//--- nf_gpio.sv
// nf_gpio
// GPIO slave with an output register and an input port
// input pins pass a two-flop synchronizer before the read register
`timescale 1ns/1ps

module nf_gpio #(
    parameter int GPIO_W = 8                    // pin count
) (
    input   logic                   clk,
    input   logic                   rst_n,
    input   nf_bus_pkg::dm_req_t    req,        // forwarded request
    input   logic                   we,         // gated write enable
    output  nf_bus_pkg::word_t      rd,         // registered read data
    input   logic   [GPIO_W-1 : 0]  gpio_in,    // async input pins
    output  logic   [GPIO_W-1 : 0]  gpio_out    // output pins
);

    import nf_bus_pkg::*;

    logic [3 : 0]           offs;               // register offset
    logic [GPIO_W-1 : 0]    in_meta;            // first sync stage
    logic [GPIO_W-1 : 0]    in_sync;            // second sync stage

    assign offs = req.addr[3 : 0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            in_meta  <= '0;
            in_sync  <= '0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
            if (we && (offs == GPIO_OUT)) begin
                gpio_out <= req.wd[GPIO_W-1 : 0];   // visible at the write edge
            end
        end
    end

    always_ff @(posedge clk) begin
        case (offs)
            GPIO_OUT: rd <= word_t'(gpio_out);  // zero-extended
            GPIO_IN:  rd <= word_t'(in_sync);
            default:  rd <= '0;                 // hole in the register map
        endcase
    end

endmodule : nf_gpio

//--- nf_tmr.sv
// nf_tmr
// compare timer slave with one-shot and periodic modes
// idle/run/done state machine around a free count register,
// tmr_irq pulses per period or stays high once a one-shot is done
`timescale 1ns/1ps

module nf_tmr (
    input   logic                   clk,
    input   logic                   rst_n,
    input   nf_bus_pkg::dm_req_t    req,        // forwarded request
    input   logic                   we,         // gated write enable
    output  nf_bus_pkg::word_t      rd,         // registered read data
    output  logic                   tmr_irq     // timer interrupt
);

    import nf_bus_pkg::*;

    tmr_state_e     state;
    tmr_mode_e      mode;                       // control register
    word_t          cnt;                        // running count
    word_t          cmp;                        // compare value
    logic [3 : 0]   offs;                       // register offset
    logic           ctrl_we;                    // control write this cycle
    logic           match;                      // count reached compare

    assign offs    = req.addr[3 : 0];
    assign ctrl_we = we && (offs == TMR_CTRL);
    assign match   = (cnt == cmp);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= TMR_IDLE;
            mode    <= TMR_OFF;
            cnt     <= '0;
            cmp     <= '0;
            tmr_irq <= 1'b0;
        end else begin
            if (we && (offs == TMR_CMP)) begin
                cmp <= req.wd;
            end
            if (ctrl_we) begin
                mode    <= tmr_mode_e'(req.wd[1 : 0]);
                tmr_irq <= 1'b0;                    // any control write clears irq
                if (req.wd[1 : 0] == TMR_OFF) begin
                    state <= TMR_IDLE;              // count held
                end else begin
                    state <= TMR_RUN;
                    cnt   <= '0;                    // restart from zero
                end
            end else begin
                case (state)
                    TMR_IDLE: tmr_irq <= 1'b0;
                    TMR_RUN: begin
                        if (match) begin
                            tmr_irq <= 1'b1;
                            if (mode == TMR_PERIODIC) begin
                                cnt <= '0;          // next period
                            end else begin
                                state <= TMR_DONE;  // one-shot, count held at compare
                            end
                        end else begin
                            cnt     <= cnt + 1'b1;
                            tmr_irq <= 1'b0;        // ends the periodic pulse
                        end
                    end
                    TMR_DONE: tmr_irq <= 1'b1;      // held until off
                    default:  state   <= TMR_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        case (offs)
            TMR_CNT:  rd <= cnt;
            TMR_CMP:  rd <= cmp;
            TMR_CTRL: rd <= {30'b0, mode};
            default:  rd <= '0;
        endcase
    end

endmodule : nf_tmr

//--- nf_dm_top.sv
// nf_dm_top
// data-memory subsystem: router with RAM, GPIO and timer slaves
`timescale 1ns/1ps

module nf_dm_top #(
    parameter int RAM_DEPTH = 64,               // ram words
    parameter int GPIO_W    = 8                 // gpio pins
) (
    input   logic                   clk,
    input   logic                   rst_n,
    input   nf_bus_pkg::dm_req_t    req,        // processor load/store request
    output  nf_bus_pkg::word_t      rd_dm,      // processor read data
    input   logic   [GPIO_W-1 : 0]  gpio_in,
    output  logic   [GPIO_W-1 : 0]  gpio_out,
    output  logic                   tmr_irq
);

    import nf_bus_pkg::*;

    slave_sel_t                 we_s;           // per slave write enable
    word_t [slave_n-1 : 0]      rd_s;           // slave read data

    nf_router nf_router_0 (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .req        ( req       ),
        .rd_dm      ( rd_dm     ),
        .we_s       ( we_s      ),
        .rd_s       ( rd_s      )
    );

    nf_ram #(
        .RAM_DEPTH  ( RAM_DEPTH )
    ) nf_ram_0 (
        .clk        ( clk               ),
        .req        ( req               ),
        .we         ( we_s[sel_ram]     ),
        .rd         ( rd_s[sel_ram]     )
    );

    nf_gpio #(
        .GPIO_W     ( GPIO_W    )
    ) nf_gpio_0 (
        .clk        ( clk               ),
        .rst_n      ( rst_n             ),
        .req        ( req               ),
        .we         ( we_s[sel_gpio]    ),
        .rd         ( rd_s[sel_gpio]    ),
        .gpio_in    ( gpio_in           ),
        .gpio_out   ( gpio_out          )
    );

    nf_tmr nf_tmr_0 (
        .clk        ( clk               ),
        .rst_n      ( rst_n             ),
        .req        ( req               ),
        .we         ( we_s[sel_tmr]     ),
        .rd         ( rd_s[sel_tmr]     ),
        .tmr_irq    ( tmr_irq           )
    );

endmodule : nf_dm_top

//--- nf_dm_sva.sv
// nf_dm_sva
// router assertions, bound into every nf_router instance
// checks one-hot write enables and that unmapped requests write nothing and read zero
`timescale 1ns/1ps

module nf_dm_sva (
    input   logic                       clk,
    input   logic                       rst_n,
    input   nf_bus_pkg::dm_req_t        req,        // master request
    input   nf_bus_pkg::slave_sel_t     we_s,       // per slave write enable
    input   nf_bus_pkg::word_t          rd_dm       // master read data
);

    import nf_bus_pkg::*;

    int     fail_cnt = 0;                           // failed assertions
    word_t  page;                                   // address bits under the mask
    logic   unmapped;                               // address outside the map

    assign page     = req.addr & slave_mask;
    assign unmapped = (page != ram_base) && (page != gpio_base) && (page != tmr_base);

    a_we_onehot : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(we_s))
        else begin
            $error("we_s enables more than one slave: %b", we_s);
            fail_cnt++;
        end

    a_unmapped_no_we : assert property (@(posedge clk) disable iff (!rst_n)
        unmapped |-> (we_s == '0))
        else begin
            $error("unmapped address %08h drives we_s %b", req.addr, we_s);
            fail_cnt++;
        end

    a_unmapped_rd_zero : assert property (@(posedge clk) disable iff (!rst_n)
        unmapped |=> (rd_dm == '0))
        else begin
            $error("read of unmapped address returned %08h", rd_dm);
            fail_cnt++;
        end

endmodule : nf_dm_sva

bind nf_router nf_dm_sva i_sva (
    .clk    ( clk   ),
    .rst_n  ( rst_n ),
    .req    ( req   ),
    .we_s   ( we_s  ),
    .rd_dm  ( rd_dm )
);

//--- nf_dm_tb.sv
// nf_dm_tb
// testbench for the data-memory subsystem
// drives load/store requests on the falling edge, keeps a model of the
// RAM, GPIO and timer registers, checks rd_dm, gpio_out and tmr_irq
`timescale 1ns/1ps

module nf_dm_tb;

    import nf_bus_pkg::*;

    localparam int    RAM_DEPTH   = 64;
    localparam int    GPIO_W      = 8;
    localparam int    AW          = $clog2(RAM_DEPTH);
    localparam int    cycle_limit = 2000;       // full run is about 350 cycles
    localparam word_t lfsr_taps   = 32'h8020_0003;

    logic                   clk;
    logic                   rst_n;
    dm_req_t                req;
    word_t                  rd_dm;
    logic [GPIO_W-1 : 0]    gpio_in;
    logic [GPIO_W-1 : 0]    gpio_out;
    logic                   tmr_irq;

    word_t                  lfsr;               // stimulus state
    word_t                  ram_m [RAM_DEPTH];  // ram model
    logic [GPIO_W-1 : 0]    gpio_out_m;
    logic [GPIO_W-1 : 0]    gpio_in_m;
    word_t                  cnt_m;              // timer count, valid when known
    word_t                  cmp_m;
    logic [1 : 0]           mode_m;
    logic                   pend;               // read check requested this cycle
    logic                   pend_q;
    word_t                  exp_rd;
    word_t                  exp_q;              // expected rd_dm after the edge
    int                     rd_err;
    int                     gpio_err;
    int                     irq_err;
    int                     total_err;
    int                     cyc;
    word_t                  unmapped_q [$];

    nf_dm_top #(
        .RAM_DEPTH  ( RAM_DEPTH ),
        .GPIO_W     ( GPIO_W    )
    ) i_dut (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .req        ( req       ),
        .rd_dm      ( rd_dm     ),
        .gpio_in    ( gpio_in   ),
        .gpio_out   ( gpio_out  ),
        .tmr_irq    ( tmr_irq   )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                 // 100 ns period
    end

    function automatic word_t lfsr_next(input word_t s);
        word_t n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ lfsr_taps;                  // galois feedback
        end
        return n;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30 : 0], lfsr[0]};        // one step per bit
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // expected read word from the address map and the register models
    function automatic word_t ref_read(input word_t addr);
        word_t          page;
        logic [3 : 0]   offs;
        word_t          r;
        page = addr & slave_mask;
        offs = addr[3 : 0];
        r    = '0;                              // unmapped reads zero
        if (page == ram_base) begin
            r = ram_m[(addr >> 2) % RAM_DEPTH];
        end else if (page == gpio_base) begin
            if (offs == GPIO_OUT) r = word_t'(gpio_out_m);
            if (offs == GPIO_IN)  r = word_t'(gpio_in_m);
        end else if (page == tmr_base) begin
            if (offs == TMR_CNT)  r = cnt_m;
            if (offs == TMR_CMP)  r = cmp_m;
            if (offs == TMR_CTRL) r = word_t'(mode_m);
        end
        return r;
    endfunction

    function automatic void model_write(input word_t addr, input word_t wd);
        word_t          page;
        logic [3 : 0]   offs;
        page = addr & slave_mask;
        offs = addr[3 : 0];
        if (page == ram_base) begin
            ram_m[(addr >> 2) % RAM_DEPTH] = wd;
        end else if (page == gpio_base && offs == GPIO_OUT) begin
            gpio_out_m = wd[GPIO_W-1 : 0];
        end else if (page == tmr_base && offs == TMR_CMP) begin
            cmp_m = wd;
        end else if (page == tmr_base && offs == TMR_CTRL) begin
            mode_m = wd[1 : 0];
            if (wd[1 : 0] != TMR_OFF) cnt_m = '0;   // restart from zero
        end
    endfunction

    task automatic check_rd(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            rd_err++;
            $display("[FAIL] %0t ns: %s, rd_dm %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_gpio(input logic [GPIO_W-1 : 0] got, input logic [GPIO_W-1 : 0] exp);
        if (got !== exp) begin
            gpio_err++;
            $display("[FAIL] %0t ns: gpio_out %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_irq(input logic got, input logic exp);
        if (got !== exp) begin
            irq_err++;
            $display("[FAIL] %0t ns: tmr_irq %b, expected %b", $time, got, exp);
        end
    endtask

    // one request per cycle, called on a falling edge
    task automatic drive_access(input word_t addr, input logic we, input word_t wd,
                                input logic chk);
        req.addr = addr;
        req.we   = we;
        req.wd   = wd;
        exp_rd   = ref_read(addr);              // read-first, before the write
        pend     = chk;
        if (we) model_write(addr, wd);
        @(negedge clk);
    endtask

    task automatic idle_cycles(input int n);
        req  = '0;
        pend = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    // compare one cycle after each checked read
    always @(posedge clk) begin
        pend_q <= pend;
        exp_q  <= exp_rd;
    end

    always @(negedge clk) begin
        if (pend_q === 1'b1) begin
            check_rd(rd_dm, exp_q, "read data");
        end
    end

    initial begin
        cyc = 0;
        while (cyc < cycle_limit) begin
            @(posedge clk);
            cyc++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Errors found");
        $finish;
    end

    initial begin
        word_t                  addr;
        logic [GPIO_W-1 : 0]    g;
        int                     c;
        rst_n      = 1'b0;
        req        = '0;
        gpio_in    = '0;
        gpio_in_m  = '0;
        gpio_out_m = '0;
        cnt_m      = '0;
        cmp_m      = '0;
        mode_m     = TMR_OFF;
        pend       = 1'b0;
        exp_rd     = '0;
        lfsr       = 32'hffc7;
        rd_err     = 0;
        gpio_err   = 0;
        irq_err    = 0;
        repeat (4) @(posedge clk);              // 4 reset edges
        @(negedge clk);
        check_rd(rd_dm, '0, "reset value");
        check_gpio(gpio_out, '0);
        check_irq(tmr_irq, 1'b0);
        rst_n = 1'b1;

        for (int i = 0; i < RAM_DEPTH; i++) begin
            drive_access(ram_base + (word_t'(i) << 2), 1'b1, rand_bits(32), 1'b0);
        end
        for (int i = 0; i < RAM_DEPTH; i++) begin
            drive_access(ram_base + (rand_bits(AW) << 2), 1'b0, '0, 1'b1);
        end
        addr = ram_base + (rand_bits(AW) << 2);
        drive_access(addr, 1'b1, rand_bits(32), 1'b1);  // old word expected
        drive_access(addr, 1'b0, '0, 1'b1);

        repeat (8) begin
            addr = rand_bits(32) | 32'h8000_0000;       // above every base
            unmapped_q.push_back(addr);
            drive_access(addr, 1'b1, rand_bits(32), 1'b0);
        end
        foreach (unmapped_q[i]) drive_access(unmapped_q[i], 1'b0, '0, 1'b1);
        for (int i = 0; i < RAM_DEPTH; i++) begin
            drive_access(ram_base + (word_t'(i) << 2), 1'b0, '0, 1'b1);
        end
        drive_access(gpio_base | word_t'(GPIO_OUT), 1'b0, '0, 1'b1);
        drive_access(tmr_base | word_t'(TMR_CMP), 1'b0, '0, 1'b1);
        drive_access(tmr_base | word_t'(TMR_CTRL), 1'b0, '0, 1'b1);

        repeat (4) begin
            g = GPIO_W'(rand_bits(GPIO_W));
            drive_access(gpio_base | word_t'(GPIO_OUT), 1'b1, word_t'(g), 1'b0);
            check_gpio(gpio_out, gpio_out_m);
            drive_access(gpio_base | word_t'(GPIO_OUT), 1'b0, '0, 1'b1);
        end
        g         = GPIO_W'(rand_bits(GPIO_W));
        gpio_in   = g;
        gpio_in_m = g;
        idle_cycles(3);                         // synchronizer delay
        drive_access(gpio_base | word_t'(GPIO_IN), 1'b0, '0, 1'b1);

        c = 2 + int'(rand_bits(3));
        drive_access(tmr_base | word_t'(TMR_CMP), 1'b1, word_t'(c), 1'b0);
        drive_access(tmr_base | word_t'(TMR_CTRL), 1'b1, word_t'(TMR_ONESHOT), 1'b0);
        for (int k = 1; k <= c + 1; k++) begin
            idle_cycles(1);
            check_irq(tmr_irq, k == c + 1);     // rises c+1 edges after start
        end
        cnt_m = word_t'(c);                     // one-shot holds count at compare
        drive_access(tmr_base | word_t'(TMR_CNT), 1'b0, '0, 1'b1);
        drive_access(tmr_base | word_t'(TMR_CTRL), 1'b0, '0, 1'b1);
        check_irq(tmr_irq, 1'b1);
        drive_access(tmr_base | word_t'(TMR_CTRL), 1'b1, word_t'(TMR_OFF), 1'b0);
        check_irq(tmr_irq, 1'b0);

        c = 2 + int'(rand_bits(3));
        drive_access(tmr_base | word_t'(TMR_CMP), 1'b1, word_t'(c), 1'b0);
        drive_access(tmr_base | word_t'(TMR_CTRL), 1'b1, word_t'(TMR_PERIODIC), 1'b0);
        for (int k = 1; k <= 3 * (c + 1); k++) begin
            idle_cycles(1);
            check_irq(tmr_irq, (k % (c + 1)) == 0); // one-cycle pulse per period
        end
        drive_access(tmr_base | word_t'(TMR_CTRL), 1'b1, word_t'(TMR_OFF), 1'b0);
        check_irq(tmr_irq, 1'b0);

        idle_cycles(2);                         // let the last compare run
        total_err = rd_err + gpio_err + irq_err + i_dut.nf_router_0.i_sva.fail_cnt;
        $display("error counts: rd_dm %0d, gpio_out %0d, tmr_irq %0d, assertions %0d",
                 rd_err, gpio_err, irq_err, i_dut.nf_router_0.i_sva.fail_cnt);
        if (total_err == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : nf_dm_tb

//--- vlog.f
nf_bus_pkg.sv
nf_router_dec.sv
nf_router.sv
nf_ram.sv
nf_gpio.sv
nf_tmr.sv
nf_dm_top.sv
nf_dm_sva.sv
nf_dm_tb.sv
